//--- rtl/adc_if_pkg.sv
// shared types for the serial adc receive path, imported by every rtl module of the design
`default_nettype none

package adc_if_pkg;

  // ******************************
  // widths that carry a meaning
  // ******************************

  // one adc code, right aligned, upper bits stay zero at 16 bit resolution
  typedef logic [17:0] sample_t;

  // ref_clk cycles inside one conversion period
  typedef logic [9:0] tick_t;

  // bits captured so far in the current gate window
  typedef logic [4:0] bit_count_t;

  // free running event counter, wraps silently
  typedef logic [15:0] count_t;

  // ******************************
  // status and state machines
  // ******************************

  // sample_count counts deliveries made while adc_dovf was low
  // overflow_count counts deliveries made while adc_dovf was high, those samples still go out
  typedef struct packed {
    count_t sample_count;
    count_t overflow_count;
  } adc_status_t;

  // conversion pacing, IDLE is left once after reset and never entered again
  typedef enum logic [1:0] {
    IDLE,
    CONVERT,
    GATE,
    WAIT
  } cnv_state_t;

endpackage

`default_nettype wire

//--- rtl/cnv_timing.sv
// paces adc conversions with a cnv pulse and opens the clk_gate window once the conversion is done
`timescale 1ns/1ps
`default_nettype none

module cnv_timing
  import adc_if_pkg::*;
#(
  parameter int CYCLE_TICKS = 40,
  parameter int CONV_TICKS  = 16,
  parameter int RESOLUTION  = 18,
  parameter int TWO_LANES   = 1
) (
  input  logic ref_clk,
  input  logic reset,
  output logic cnv,
  output logic clk_gate
);

  // ******************************
  // window geometry
  // ******************************

  // with two lanes every gated clock moves a pair of bits, so the window
  // only needs half as many cycles as the resolution
  localparam int BITS_PER_LANE = (TWO_LANES != 0) ? RESOLUTION / 2 : RESOLUTION;

  // tick values are relative to the cycle in which cnv is high (tick zero)
  // and each one names the last cycle before the output changes
  localparam tick_t GATE_OPEN_TICK  = tick_t'(CONV_TICKS - 1);
  localparam tick_t GATE_CLOSE_TICK = tick_t'(CONV_TICKS + BITS_PER_LANE - 1);
  localparam tick_t PERIOD_END_TICK = tick_t'(CYCLE_TICKS - 1);

  cnv_state_t state;
  tick_t      tick;

  // ******************************
  // period state machine
  // ******************************

  // the counter runs through the whole period and is only cleared when a
  // new cnv is issued, so every decision below is a plain compare on tick
  always_ff @(posedge ref_clk) begin
    if (reset) begin
      state    <= IDLE;
      tick     <= '0;
      cnv      <= 1'b0;
      clk_gate <= 1'b0;
    end else begin
      // cnv is a single cycle pulse unless a branch below restarts the period
      cnv  <= 1'b0;
      tick <= tick + tick_t'(1);

      case (state)
        IDLE: begin
          // first conversion starts on the first cycle out of reset
          cnv   <= 1'b1;
          tick  <= '0;
          state <= CONVERT;
        end

        CONVERT: begin
          // the adc is busy converting, no clocks may reach it here
          if (tick == GATE_OPEN_TICK) begin
            clk_gate <= 1'b1;
            state    <= GATE;
          end
        end

        GATE: begin
          // one gated clock per cycle, one or two bits per clock
          if (tick == GATE_CLOSE_TICK) begin
            clk_gate <= 1'b0;
            state    <= WAIT;
          end
        end

        WAIT: begin
          // acquisition time for the sampling capacitor before the next cnv
          if (tick == PERIOD_END_TICK) begin
            cnv   <= 1'b1;
            tick  <= '0;
            state <= CONVERT;
          end
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/lane_deserializer.sv
// collects the serial bits of one or two adc lanes into a sample, used behind the cnv timing block
`timescale 1ns/1ps
`default_nettype none

module lane_deserializer
  import adc_if_pkg::*;
#(
  parameter int RESOLUTION = 18,
  parameter int TWO_LANES  = 1,
  parameter int ROUND_TRIP = 1
) (
  input  logic    ref_clk,
  input  logic    reset,
  input  logic    gate_window,
  input  logic    da,
  input  logic    db,
  output sample_t word,
  output logic    word_valid
);

  localparam int SAMPLE_W = $bits(sample_t);

  // bits taken per captured cycle
  localparam bit_count_t LANE_STEP = (TWO_LANES != 0) ? bit_count_t'(2) : bit_count_t'(1);

  // keeps the sample right aligned for the 16 bit parts
  localparam sample_t RES_MASK = sample_t'((1 << RESOLUTION) - 1);

  // ******************************
  // gate alignment
  // ******************************

  // gate_line[0] is the gate as issued and gate_line[i] the gate i cycles
  // later, so the top entry lines up with the data coming back from the adc
  logic [ROUND_TRIP-1:0] gate_dly;
  logic [ROUND_TRIP:0]   gate_line;
  logic                  gate_d;
  logic                  gate_d_next;
  logic                  last_bit;

  assign gate_line   = {gate_dly, gate_window};
  assign gate_d      = gate_line[ROUND_TRIP];
  assign gate_d_next = gate_line[ROUND_TRIP-1];

  // the window closes after this cycle, so the bits on the lanes now are
  // the last ones of the code
  assign last_bit = gate_d & ~gate_d_next;

  always_ff @(posedge ref_clk) begin
    if (reset) begin
      gate_dly <= '0;
    end else begin
      gate_dly <= gate_line[ROUND_TRIP-1:0];
    end
  end

  // ******************************
  // shift register
  // ******************************

  sample_t    shift_reg;
  sample_t    shift_base;
  sample_t    shift_next;
  bit_count_t bit_count;

  // the first bit of a window starts from an empty register, so leftovers
  // from the previous code never show up in the upper bits
  always_comb begin
    shift_base = (bit_count == '0) ? '0 : shift_reg;
    if (TWO_LANES != 0) begin
      // da holds the more significant bit of each pair
      shift_next = {shift_base[SAMPLE_W-3:0], da, db};
    end else begin
      shift_next = {shift_base[SAMPLE_W-2:0], da};
    end
  end

  // bit counter and output strobe
  always_ff @(posedge ref_clk) begin
    if (reset) begin
      bit_count  <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      if (gate_d) begin
        if (last_bit) begin
          bit_count  <= '0;
          word_valid <= 1'b1;
        end else begin
          bit_count <= bit_count + LANE_STEP;
        end
      end
    end
  end

  // sample data, meaningful only while the matching strobe is set
  always_ff @(posedge ref_clk) begin
    if (gate_d) begin
      shift_reg <= shift_next;
    end
    if (last_bit) begin
      word <= shift_next & RES_MASK;
    end
  end

endmodule

`default_nettype wire

//--- rtl/sample_output.sv
// hands finished samples to the dma side and keeps the delivered and lost sample counts
`timescale 1ns/1ps
`default_nettype none

module sample_output
  import adc_if_pkg::*;
(
  input  logic        ref_clk,
  input  logic        reset,
  input  sample_t     word,
  input  logic        word_valid,
  input  logic        adc_dovf,
  output sample_t     adc_data,
  output logic        adc_valid,
  output adc_status_t status
);

  // ******************************
  // sink side register
  // ******************************

  // the sink has no way to stall us, a new word can only arrive once per
  // conversion period so a single register stage is enough
  always_ff @(posedge ref_clk) begin
    if (word_valid) begin
      adc_data <= word;
    end
  end

  always_ff @(posedge ref_clk) begin
    if (reset) begin
      adc_valid <= 1'b0;
    end else begin
      adc_valid <= word_valid;
    end
  end

  // ******************************
  // delivery accounting
  // ******************************

  // adc_dovf is judged in the cycle the sample is on the bus, the sample
  // still goes out but only one of the two counters moves
  always_ff @(posedge ref_clk) begin
    if (reset) begin
      status <= '0;
    end else if (adc_valid) begin
      if (adc_dovf) begin
        status.overflow_count <= status.overflow_count + count_t'(1);
      end else begin
        status.sample_count <= status.sample_count + count_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/adc_if_top.sv
// top of the serial adc receive path, connects conversion timing, lane capture and the sink stage
`timescale 1ns/1ps
`default_nettype none

module adc_if_top
  import adc_if_pkg::*;
#(
  parameter int RESOLUTION  = 18,
  parameter int TWO_LANES   = 1,
  parameter int CYCLE_TICKS = 40,
  parameter int CONV_TICKS  = 16
) (
  input  logic        ref_clk,
  input  logic        reset,
  input  logic        da,
  input  logic        db,
  input  logic        adc_dovf,
  output logic        cnv,
  output logic        clk_gate,
  output sample_t     adc_data,
  output logic        adc_valid,
  output adc_status_t status
);

  // cycles between a gated clock leaving the fpga and its bit being
  // stable at the capture flops
  localparam int ROUND_TRIP = 1;

  // ******************************
  // internal nets
  // ******************************

  sample_t word;
  logic    word_valid;

  // conversion pacing and bit clock window
  cnv_timing #(
    .CYCLE_TICKS (CYCLE_TICKS),
    .CONV_TICKS  (CONV_TICKS),
    .RESOLUTION  (RESOLUTION),
    .TWO_LANES   (TWO_LANES)
  ) i_cnv_timing (
    .ref_clk  (ref_clk),
    .reset    (reset),
    .cnv      (cnv),
    .clk_gate (clk_gate)
  );

  // the same gate that enables the adc clock also frames the capture
  lane_deserializer #(
    .RESOLUTION (RESOLUTION),
    .TWO_LANES  (TWO_LANES),
    .ROUND_TRIP (ROUND_TRIP)
  ) i_lane_deserializer (
    .ref_clk     (ref_clk),
    .reset       (reset),
    .gate_window (clk_gate),
    .da          (da),
    .db          (db),
    .word        (word),
    .word_valid  (word_valid)
  );

  // sink register and status counters
  sample_output i_sample_output (
    .ref_clk    (ref_clk),
    .reset      (reset),
    .word       (word),
    .word_valid (word_valid),
    .adc_dovf   (adc_dovf),
    .adc_data   (adc_data),
    .adc_valid  (adc_valid),
    .status     (status)
  );

endmodule

`default_nettype wire

//--- test/adc_model.sv
// behavioral serial adc for the testbench, shifts queued codes out MSB first on gated clock cycles
`timescale 1ns/1ps
`default_nettype none

module adc_model #(
  parameter int RESOLUTION = 18,
  parameter int TWO_LANES  = 1
) (
  input  logic        ref_clk,
  input  logic        clk_gate,
  input  logic [17:0] code_in,
  input  logic        code_push,
  output logic        da,
  output logic        db
);

  // one gated clock per pair of bits with two lanes, one per bit otherwise
  localparam int BITS_PER_LANE = (TWO_LANES != 0) ? RESOLUTION / 2 : RESOLUTION;

  logic [17:0] codes[$];
  logic [17:0] shifter;
  logic        gate_seen;
  int          bit_index;

  initial begin
    da        = 1'b0;
    db        = 1'b0;
    gate_seen = 1'b0;
    shifter   = '0;
    bit_index = 0;
  end

  // the gate is looked at mid cycle, so a rising edge counts as a gated
  // clock when the gate was high during the cycle that it ends
  always @(negedge ref_clk) begin
    gate_seen = clk_gate;
  end

  always @(posedge ref_clk) begin
    if (code_push) begin
      codes.push_back(code_in);
    end
    if (gate_seen) begin
      // a new code starts with the first gated clock of a window
      // and an empty queue reads as a zero code
      if (bit_index == 0) begin
        shifter = '0;
        if (codes.size() > 0) begin
          shifter = codes.pop_front();
        end
        shifter = shifter << (18 - RESOLUTION);
      end
      // clock to output delay of the adc
      #2;
      da        = shifter[17];
      db        = (TWO_LANES != 0) ? shifter[16] : 1'b0;
      shifter   = (TWO_LANES != 0) ? shifter << 2 : shifter << 1;
      bit_index = (bit_index == BITS_PER_LANE - 1) ? 0 : bit_index + 1;
    end
  end

endmodule

`default_nettype wire

//--- test/system_tb.sv
// directed testbench for the adc receive path, runs adc_if_top beside a behavioral adc model
`timescale 1ns/1ps
`default_nettype none

module system_tb
  import adc_if_pkg::*;
();

  localparam int RESOLUTION    = 18;
  localparam int TWO_LANES     = 1;
  localparam int CYCLE_TICKS   = 40;
  localparam int CONV_TICKS    = 16;
  localparam int BITS_PER_LANE = (TWO_LANES != 0) ? RESOLUTION / 2 : RESOLUTION;
  // conversion, gate window, one cycle round trip and the output register
  localparam int LATENCY       = CONV_TICKS + BITS_PER_LANE + 1 + 1;
  localparam int WAIT_LIMIT    = 4 * CYCLE_TICKS;

  logic        ref_clk;
  logic        reset;
  logic        adc_dovf;
  logic        da;
  logic        db;
  logic        cnv;
  logic        clk_gate;
  logic        adc_valid;
  sample_t     adc_data;
  adc_status_t status;
  sample_t     code_in;
  logic        code_push;
  logic [31:0] lfsr_state;
  int          test_errors;
  int          total_errors;
  int          tests_run;
  int          tests_failed;

  adc_if_top #(
    .RESOLUTION  (RESOLUTION),
    .TWO_LANES   (TWO_LANES),
    .CYCLE_TICKS (CYCLE_TICKS),
    .CONV_TICKS  (CONV_TICKS)
  ) DUT (
    .ref_clk   (ref_clk),
    .reset     (reset),
    .da        (da),
    .db        (db),
    .adc_dovf  (adc_dovf),
    .cnv       (cnv),
    .clk_gate  (clk_gate),
    .adc_data  (adc_data),
    .adc_valid (adc_valid),
    .status    (status)
  );

  adc_model #(
    .RESOLUTION (RESOLUTION),
    .TWO_LANES  (TWO_LANES)
  ) model (
    .ref_clk   (ref_clk),
    .clk_gate  (clk_gate),
    .code_in   (code_in),
    .code_push (code_push),
    .da        (da),
    .db        (db)
  );

  always #50 ref_clk = ~ref_clk;

  // ******************************
  // helpers
  // ******************************

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_advance(input logic [31:0] state);
    logic [31:0] shifted;
    shifted = state >> 1;
    if (state[0]) begin
      shifted = shifted ^ 32'h8020_0003;
    end
    return shifted;
  endfunction

  // one lfsr step per code bit, the bits fill the code from the MSB down
  task automatic draw_code(output sample_t code);
    code = '0;
    for (int i = 0; i < RESOLUTION; i++) begin
      lfsr_state = lfsr_advance(lfsr_state);
      code = {code[$bits(sample_t)-2:0], lfsr_state[0]};
    end
  endtask

  // outputs are read and inputs driven at the same point, 5 ns into a cycle
  task automatic next_cycle();
    @(posedge ref_clk);
    #5;
  endtask

  function automatic logic watched(input string name);
    if (name == "cnv") begin
      return cnv;
    end
    if (name == "clk_gate") begin
      return clk_gate;
    end
    return adc_valid;
  endfunction

  // steps at least once, then until the output reaches the level
  task automatic wait_until(input string test_name, input string name, input logic level,
                            output int cycles);
    cycles = 0;
    do begin
      next_cycle();
      cycles++;
    end while (watched(name) !== level && cycles < WAIT_LIMIT);
    if (watched(name) !== level) begin
      $display("%s: %s did not go to %b within %0d cycles", test_name, name, level, cycles);
      test_errors++;
    end
  endtask

  task automatic report_mismatch(input string test_name, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
    $display("ERROR %s: %s expected 'h%0h, actual 'h%0h", test_name, what, expected, actual);
    test_errors++;
  endtask

  task automatic close_test(input string test_name);
    tests_run++;
    if (test_errors == 0) begin
      $display("%s: ok", test_name);
    end else begin
      $display("%s: %0d errors", test_name, test_errors);
      tests_failed++;
      total_errors += test_errors;
    end
    test_errors = 0;
  endtask

  // queues one code right after a cnv and checks what comes back and when
  task automatic send_and_check(input string test_name, input sample_t code);
    int waited;
    wait_until(test_name, "cnv", 1'b1, waited);
    code_in   = code;
    code_push = 1'b1;
    next_cycle();
    code_push = 1'b0;
    wait_until(test_name, "adc_valid", 1'b1, waited);
    if (waited + 1 != LATENCY) begin
      report_mismatch(test_name, "latency", LATENCY, waited + 1);
    end
    if (adc_data !== code) begin
      report_mismatch(test_name, "adc_data", 32'(code), 32'(adc_data));
    end
  endtask

  // ******************************
  // directed tests
  // ******************************

  task automatic test_reset_state();
    for (int i = 0; i < 10; i++) begin
      next_cycle();
      if (cnv !== 1'b0) begin
        report_mismatch("reset_state", "cnv", 0, 32'(cnv));
      end
      if (adc_valid !== 1'b0 || clk_gate !== 1'b0) begin
        report_mismatch("reset_state", "valid and gate", 0, 32'({adc_valid, clk_gate}));
      end
      if (status !== '0) begin
        report_mismatch("reset_state", "status", 0, status);
      end
    end
    reset = 1'b0;
    next_cycle();
    // the first conversion is issued on the first cycle out of reset
    if (cnv !== 1'b1) begin
      report_mismatch("reset_state", "first cnv", 1, 32'(cnv));
    end
    if (adc_valid !== 1'b0 || clk_gate !== 1'b0) begin
      report_mismatch("reset_state", "valid and gate", 0, 32'({adc_valid, clk_gate}));
    end
    if (status !== '0) begin
      report_mismatch("reset_state", "status", 0, status);
    end
    close_test("reset_state");
  endtask

  task automatic test_conversion_pacing();
    int to_gate;
    int width;
    int to_cnv;
    wait_until("conversion_pacing", "cnv", 1'b1, to_cnv);
    for (int p = 0; p < 4; p++) begin
      wait_until("conversion_pacing", "clk_gate", 1'b1, to_gate);
      wait_until("conversion_pacing", "clk_gate", 1'b0, width);
      wait_until("conversion_pacing", "cnv", 1'b1, to_cnv);
      if (to_gate != CONV_TICKS) begin
        report_mismatch("conversion_pacing", "cnv to gate", CONV_TICKS, to_gate);
      end
      if (width != BITS_PER_LANE) begin
        report_mismatch("conversion_pacing", "gate width", BITS_PER_LANE, width);
      end
      if (to_gate + width + to_cnv != CYCLE_TICKS) begin
        report_mismatch("conversion_pacing", "cnv period", CYCLE_TICKS, to_gate + width + to_cnv);
      end
    end
    close_test("conversion_pacing");
  endtask

  task automatic test_data_integrity();
    sample_t code;
    count_t  delivered;
    int      waited;
    // start counting just after a delivery has been accounted
    wait_until("data_integrity", "adc_valid", 1'b1, waited);
    next_cycle();
    delivered = status.sample_count;
    for (int i = 0; i < 20; i++) begin
      draw_code(code);
      send_and_check("data_integrity", code);
    end
    next_cycle();
    if (status.sample_count !== delivered + count_t'(20)) begin
      report_mismatch("data_integrity", "sample_count", 32'(delivered + count_t'(20)),
                      32'(status.sample_count));
    end
    close_test("data_integrity");
  endtask

  task automatic test_bit_order();
    sample_t codes[4];
    codes[0] = '0;
    codes[1] = sample_t'((1 << RESOLUTION) - 1);
    codes[2] = sample_t'(1 << (RESOLUTION - 1));
    codes[3] = sample_t'(1);
    for (int i = 0; i < 4; i++) begin
      send_and_check("bit_order", codes[i]);
    end
    close_test("bit_order");
  endtask

  task automatic test_overflow();
    sample_t code;
    count_t  delivered;
    count_t  lost;
    int      waited;
    wait_until("overflow", "adc_valid", 1'b1, waited);
    next_cycle();
    delivered = status.sample_count;
    lost      = status.overflow_count;
    adc_dovf  = 1'b1;
    for (int i = 0; i < 3; i++) begin
      draw_code(code);
      send_and_check("overflow", code);
    end
    // the last delivery is accounted on the edge after adc_valid
    next_cycle();
    adc_dovf = 1'b0;
    if (status.overflow_count !== lost + count_t'(3)) begin
      report_mismatch("overflow", "overflow_count", 32'(lost + count_t'(3)),
                      32'(status.overflow_count));
    end
    if (status.sample_count !== delivered) begin
      report_mismatch("overflow", "sample_count", 32'(delivered), 32'(status.sample_count));
    end
    close_test("overflow");
  endtask

  // ******************************
  // test sequence
  // ******************************

  initial begin
    ref_clk      = 1'b0;
    reset        = 1'b1;
    adc_dovf     = 1'b0;
    code_in      = '0;
    code_push    = 1'b0;
    lfsr_state   = 32'h2837_3141;
    test_errors  = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_reset_state();
    test_conversion_pacing();
    test_data_integrity();
    test_bit_order();
    test_overflow();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             total_errors);
    if (total_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- adc_if.f
rtl/adc_if_pkg.sv
rtl/cnv_timing.sv
rtl/lane_deserializer.sv
rtl/sample_output.sv
rtl/adc_if_top.sv
test/adc_model.sv
test/system_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module system_tb \
  -f adc_if.f --Mdir obj_dir -o system_tb_sim

sim_output=$(./obj_dir/system_tb_sim)
printf '%s\n' "$sim_output"

if printf '%s\n' "$sim_output" | grep -qx "Test passed"; then
  exit 0
fi
exit 1
